//--- tb.f
+incdir+include
logic/enc_pkg.sv
logic/luma_core_quant.sv
logic/chroma_dc_quant.sv
logic/exp_golomb_coder.sv
logic/byte_packer.sv
logic/intra_residual_top.sv
dv/tb_intra_residual.sv

//--- dv/tb_intra_residual.sv
`timescale 1ns/100ps
`include "enc_cfg.svh"

module tb_intra_residual;

	logic                   clk2;
	logic                   arst_n;
	logic                   mb_start;
	logic [5:0]             qp;
	logic                   luma_strobe;
	enc_pkg::residual_row_t luma_row;
	logic                   chroma_strobe;
	enc_pkg::chroma_dc_t    chroma_dc;
	logic [7:0]             byte_data;
	logic                   byte_strobe;
	logic                   mb_done;

	integer     seed;
	int         res_blk [0:3][0:3];  // [row][column]
	int         dc_val  [0:3];
	bit         stream_bits [$];
	logic [7:0] exp_bytes [$];
	logic [7:0] rx_bytes  [$];
	int         done_count;
	int         done_bytes;
	logic       in_mb;

	localparam int zigzag_order [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};
	localparam int core_mat [4][4] = '{'{1, 1, 1, 1}, '{2, 1, -1, -2}, '{1, -1, -1, 1},
		'{1, -2, 2, -1}};
	localparam int hadamard [2][2] = '{'{1, 1}, '{1, -1}};
	localparam int mf_table [6][3] = '{'{13107, 5243, 8066}, '{11916, 4660, 7490},
		'{10082, 4194, 6554}, '{9362, 3647, 5825}, '{8192, 3355, 5243}, '{7282, 2893, 4559}};

	intra_residual_top UUT
	(
		.clk2          ( clk2          ),
		.arst_n        ( arst_n        ),
		.mb_start      ( mb_start      ),
		.qp            ( qp            ),
		.luma_strobe   ( luma_strobe   ),
		.luma_row      ( luma_row      ),
		.chroma_strobe ( chroma_strobe ),
		.chroma_dc     ( chroma_dc     ),
		.byte_data     ( byte_data     ),
		.byte_strobe   ( byte_strobe   ),
		.mb_done       ( mb_done       )
	);

	initial
	begin
		clk2 = 1'b0;
		forever #10 clk2 = ~clk2;
	end

	task stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task check_value(input string name, input logic [63:0] got, input logic [63:0] expected);
		if (got !== expected)
			stop_on_error($sformatf("CHECK FAILED time=%0t signal=%s got=0x%0h expected=0x%0h",
				$time, name, got, expected));
	endtask

	function int rand_between(input int lo, input int hi);
		int r;
		r = $random(seed);
		rand_between = lo + ((r & 32'h7fffffff) % (hi - lo + 1));
	endfunction

	function automatic int position_class(input int u, input int v);
		if ((u % 2 == 0) && (v % 2 == 0))
			return 0;
		else if ((u % 2 == 1) && (v % 2 == 1))
			return 1;
		else
			return 2;
	endfunction

	function automatic int quantise(input int coef, input int mf, input int shift, input int offset);
		longint mag;
		int     lv;
		mag = (coef < 0) ? -coef : coef;
		lv  = int'((mag * mf + offset) >> shift);
		return (coef < 0) ? -lv : lv;
	endfunction

	task automatic append_se(input int lvl);
		int code_num;
		int x;
		int n;
		code_num = (lvl > 0) ? 2 * lvl - 1 : -2 * lvl;
		x        = code_num + 1;
		n        = 0;
		while ((x >> (n + 1)) != 0)
			n++;
		repeat (n)
			stream_bits.push_back(1'b0);
		for (int i = n; i >= 0; i--)
			stream_bits.push_back(bit'((x >> i) & 1));
	endtask

	// Forward transform, quantisation and se(v) coding of the current block
	task automatic build_expected(input int q);
		int         h  [4][4];
		int         w  [4][4];
		int         lv [16];
		int         cl [4];
		int         f;
		int         qbits;
		logic [7:0] b;
		qbits = 15 + q / 6;
		for (int r = 0; r < 4; r++)
			for (int k = 0; k < 4; k++)
			begin
				h[r][k] = 0;
				for (int j = 0; j < 4; j++)
					h[r][k] += core_mat[k][j] * res_blk[r][j];
			end
		for (int u = 0; u < 4; u++)
			for (int v = 0; v < 4; v++)
			begin
				w[u][v] = 0;
				for (int r = 0; r < 4; r++)
					w[u][v] += core_mat[u][r] * h[r][v];
				lv[u * 4 + v] = quantise(w[u][v], mf_table[q % 6][position_class(u, v)], qbits,
					(1 << qbits) / 3);
			end
		for (int i = 0; i < 2; i++)
			for (int j = 0; j < 2; j++)
			begin
				f = 0;
				for (int a = 0; a < 2; a++)
					for (int c = 0; c < 2; c++)
						f += hadamard[i][a] * dc_val[a * 2 + c] * hadamard[c][j];
				cl[i * 2 + j] = quantise(f, mf_table[q % 6][0], qbits + 1, 2 * ((1 << qbits) / 3));
			end
		stream_bits.delete();
		for (int k = 0; k < 16; k++)
			append_se(lv[zigzag_order[k]]);
		for (int k = 0; k < 4; k++)
			append_se(cl[k]);
		stream_bits.push_back(1'b1);  // Stop bit
		while (stream_bits.size() % 8 != 0)
			stream_bits.push_back(1'b0);
		exp_bytes.delete();
		for (int i = 0; i < stream_bits.size(); i += 8)
		begin
			for (int j = 0; j < 8; j++)
				b[7 - j] = stream_bits[i + j];
			exp_bytes.push_back(b);
		end
	endtask

	task fill_random;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				res_blk[r][c] = rand_between(-(1 << (`ENC_SAMPLE_W - 1)), (1 << (`ENC_SAMPLE_W - 1)) - 1);
		for (int k = 0; k < 4; k++)
			dc_val[k] = rand_between(-(1 << (`ENC_DC_IN_W - 1)), (1 << (`ENC_DC_IN_W - 1)) - 1);
	endtask

	task fill_full_scale;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				res_blk[r][c] = rand_between(0, 1) ? (1 << (`ENC_SAMPLE_W - 1)) - 1
					: -(1 << (`ENC_SAMPLE_W - 1));
		for (int k = 0; k < 4; k++)
			dc_val[k] = rand_between(0, 1) ? (1 << (`ENC_DC_IN_W - 1)) - 1 : -(1 << (`ENC_DC_IN_W - 1));
	endtask

	task send_luma_row(input int r);
		enc_pkg::residual_row_t row;
		row.s0 = res_blk[r][0];
		row.s1 = res_blk[r][1];
		row.s2 = res_blk[r][2];
		row.s3 = res_blk[r][3];
		@(posedge clk2);
		luma_row    <= row;
		luma_strobe <= 1'b1;
		@(posedge clk2);
		luma_strobe <= 1'b0;
		repeat (rand_between(0, 2))
			@(posedge clk2);
	endtask

	task send_chroma;
		enc_pkg::chroma_dc_t dc;
		dc.d0 = dc_val[0];
		dc.d1 = dc_val[1];
		dc.d2 = dc_val[2];
		dc.d3 = dc_val[3];
		@(posedge clk2);
		chroma_dc     <= dc;
		chroma_strobe <= 1'b1;
		@(posedge clk2);
		chroma_strobe <= 1'b0;
	endtask

	// Chroma goes before luma row c_pos, or after all rows when c_pos is 4
	task run_mb(input int q, input int c_pos);
		int start_done;
		int waited;
		build_expected(q);
		start_done = done_count;
		@(posedge clk2);
		rx_bytes.delete();
		in_mb = 1'b1;
		mb_start <= 1'b1;
		qp       <= 6'(q);
		@(posedge clk2);
		mb_start <= 1'b0;
		for (int slot = 0; slot < 5; slot++)
		begin
			if (slot == c_pos)
				send_chroma();
			if (slot < 4)
				send_luma_row(slot);
		end
		waited = 0;
		while (done_count == start_done)
		begin
			@(negedge clk2);
			waited++;
			if (waited > 3000)
				stop_on_error("Timeout while waiting for mb_done");
		end
		check_value("byte count", rx_bytes.size(), exp_bytes.size());
		check_value("byte count at mb_done", done_bytes, exp_bytes.size());
		for (int i = 0; i < exp_bytes.size(); i++)
			check_value($sformatf("byte_data[%0d]", i), rx_bytes[i], exp_bytes[i]);
		repeat (3)
			@(negedge clk2);
		check_value("mb_done count", done_count, start_done + 1);
	endtask

	// Output monitor, sampled away from the driving edge
	always @(negedge clk2)
	begin
		if (arst_n)
		begin
			if (byte_strobe)
			begin
				if (!in_mb)
					stop_on_error("byte_strobe seen while no macroblock was in progress");
				rx_bytes.push_back(byte_data);
			end
			if (mb_done)
			begin
				if (!in_mb)
					stop_on_error("mb_done seen while no macroblock was in progress");
				done_bytes = rx_bytes.size();
				done_count++;
				in_mb = 1'b0;
			end
		end
	end

	initial
	begin
		seed          = 32'h253f;
		arst_n        = 1'b0;
		mb_start      = 1'b0;
		qp            = '0;
		luma_strobe   = 1'b0;
		luma_row      = '0;
		chroma_strobe = 1'b0;
		chroma_dc     = '0;
		in_mb         = 1'b0;
		done_count    = 0;
		done_bytes    = 0;
		repeat (10)
			@(posedge clk2);
		arst_n <= 1'b1;
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clk2);
			check_value("byte_strobe", byte_strobe, 1'b0);
			check_value("mb_done", mb_done, 1'b0);
		end
		for (int r = 0; r < 4; r++)
		begin
			dc_val[r] = 0;
			for (int c = 0; c < 4; c++)
				res_blk[r][c] = 0;
		end
		run_mb(rand_between(0, 51), 4);
		check_value("zero block byte count", rx_bytes.size(), 3);
		check_value("zero block byte 0", rx_bytes[0], 8'hff);
		check_value("zero block byte 1", rx_bytes[1], 8'hff);
		check_value("zero block byte 2", rx_bytes[2], 8'hf8);
		for (int i = 0; i < 6; i++)
		begin
			fill_full_scale();
			run_mb((i < 3) ? 0 : 51, rand_between(0, 4));  // Longest codes at qp 0
		end
		for (int pos = 0; pos < 5; pos++)
		begin
			fill_random();
			run_mb(rand_between(0, 51), pos);
		end
		for (int i = 0; i < 40; i++)
		begin
			fill_random();
			run_mb(rand_between(0, 51), rand_between(0, 4));
		end
		$display("Test OK");
		$finish;
	end

endmodule

//--- logic/intra_residual_top.sv
`timescale 1ns/100ps

module intra_residual_top
(
	input  logic                   clk2,
	input  logic                   arst_n,
	input  logic                   mb_start,
	input  logic [5:0]             qp,
	input  logic                   luma_strobe,
	input  enc_pkg::residual_row_t luma_row,
	input  logic                   chroma_strobe,
	input  enc_pkg::chroma_dc_t    chroma_dc,
	output logic [7:0]             byte_data,
	output logic                   byte_strobe,
	output logic                   mb_done
);

	logic               luma_ready;
	logic               luma_level_valid;
	enc_pkg::level_t    luma_level;
	logic [3:0]         luma_idx;
	logic               chroma_ready;
	enc_pkg::level_t    chroma_level;
	logic [1:0]         chroma_idx;
	logic               take;
	enc_pkg::vlc_code_t code;
	logic               code_strobe;
	logic               flush;
	logic               pack_hold;

	luma_core_quant ins_luma
	(
		.clk2             ( clk2             ),
		.arst_n           ( arst_n           ),
		.mb_start         ( mb_start         ),
		.qp               ( qp               ),
		.luma_strobe      ( luma_strobe      ),
		.luma_row         ( luma_row         ),
		.take             ( take             ),
		.level_idx        ( luma_idx         ),
		.luma_ready       ( luma_ready       ),
		.luma_level       ( luma_level       ),
		.luma_level_valid ( luma_level_valid )
	);

	chroma_dc_quant ins_chroma
	(
		.clk2          ( clk2          ),
		.arst_n        ( arst_n        ),
		.mb_start      ( mb_start      ),
		.qp            ( qp            ),
		.chroma_strobe ( chroma_strobe ),
		.chroma_dc     ( chroma_dc     ),
		.take          ( take          ),
		.level_idx     ( chroma_idx    ),
		.chroma_ready  ( chroma_ready  ),
		.chroma_level  ( chroma_level  )
	);

	exp_golomb_coder ins_coder
	(
		.clk2             ( clk2             ),
		.arst_n           ( arst_n           ),
		.luma_ready       ( luma_ready       ),
		.luma_level_valid ( luma_level_valid ),
		.luma_level       ( luma_level       ),
		.chroma_ready     ( chroma_ready     ),
		.chroma_level     ( chroma_level     ),
		.pack_hold        ( pack_hold        ),
		.luma_idx         ( luma_idx         ),
		.chroma_idx       ( chroma_idx       ),
		.take             ( take             ),
		.code             ( code             ),
		.code_strobe      ( code_strobe      ),
		.flush            ( flush            )
	);

	byte_packer ins_packer
	(
		.clk2        ( clk2        ),
		.arst_n      ( arst_n      ),
		.code        ( code        ),
		.code_strobe ( code_strobe ),
		.flush       ( flush       ),
		.pack_hold   ( pack_hold   ),
		.byte_data   ( byte_data   ),
		.byte_strobe ( byte_strobe ),
		.mb_done     ( mb_done     )
	);

endmodule

//--- logic/byte_packer.sv
`timescale 1ns/100ps

module byte_packer
(
	input  logic               clk2,
	input  logic               arst_n,
	input  enc_pkg::vlc_code_t code,
	input  logic               code_strobe,
	input  logic               flush,
	output logic               pack_hold,
	output logic [7:0]         byte_data,
	output logic               byte_strobe,
	output logic               mb_done
);

	logic [39:0] acc;       // Pending bits sit in acc[cnt-1:0]
	logic [5:0]  cnt;
	logic        draining;

	assign pack_hold = (cnt >= 6'd8);

	always_ff @(posedge clk2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt         <= '0;
			draining    <= 1'b0;
			byte_strobe <= 1'b0;
			mb_done     <= 1'b0;
		end
		else
		begin
			byte_strobe <= pack_hold;
			mb_done     <= draining && (cnt == 6'd0);
			if (pack_hold)
				cnt <= cnt - 6'd8;
			else if (flush)
			begin
				cnt      <= 6'd8;  // Stop bit plus padding always lands on one byte
				draining <= 1'b1;
			end
			else if (code_strobe)
				cnt <= cnt + 6'(code.len);
			if (draining && cnt == 6'd0)
				draining <= 1'b0;
		end
	end

	always_ff @(posedge clk2)
	begin
		if (pack_hold)
			byte_data <= acc[cnt - 6'd1 -: 8];
		else if (flush)
			acc <= ((acc << 1) | 40'd1) << (6'd7 - cnt);
		else if (code_strobe)
			acc <= (acc << code.len) | 40'(code.bits);
	end

endmodule

//--- logic/exp_golomb_coder.sv
`timescale 1ns/100ps
`include "enc_cfg.svh"

module exp_golomb_coder
(
	input  logic               clk2,
	input  logic               arst_n,
	input  logic               luma_ready,
	input  logic               luma_level_valid,
	input  enc_pkg::level_t    luma_level,
	input  logic               chroma_ready,
	input  enc_pkg::level_t    chroma_level,
	input  logic               pack_hold,
	output logic [3:0]         luma_idx,
	output logic [1:0]         chroma_idx,
	output logic               take,
	output enc_pkg::vlc_code_t code,
	output logic               code_strobe,
	output logic               flush
);

	enc_pkg::coder_state_t state;
	logic [3:0]            step;
	enc_pkg::level_t       cur;
	logic signed [17:0]    v;
	logic [16:0]           code_num;
	logic [16:0]           info;
	logic [4:0]            zeros;

	function automatic logic [3:0] zigzag(input logic [3:0] k);
		case (k)
			4'd0:    zigzag = 4'd0;
			4'd1:    zigzag = 4'd1;
			4'd2:    zigzag = 4'd4;
			4'd3:    zigzag = 4'd8;
			4'd4:    zigzag = 4'd5;
			4'd5:    zigzag = 4'd2;
			4'd6:    zigzag = 4'd3;
			4'd7:    zigzag = 4'd6;
			4'd8:    zigzag = 4'd9;
			4'd9:    zigzag = 4'd12;
			4'd10:   zigzag = 4'd13;
			4'd11:   zigzag = 4'd10;
			4'd12:   zigzag = 4'd7;
			4'd13:   zigzag = 4'd11;
			4'd14:   zigzag = 4'd14;
			default: zigzag = 4'd15;
		endcase
	endfunction

	assign luma_idx   = zigzag(step);
	assign chroma_idx = step[1:0];
	assign cur        = (state == enc_pkg::CS_CHROMA) ? chroma_level : luma_level;

	always_comb
	begin
		v        = cur;
		code_num = (v > 0) ? 17'((v <<< 1) - 18'sd1) : 17'(-(v <<< 1));
		info     = code_num + 17'd1;
		zeros    = '0;
		for (int i = 1; i < 17; i++)
		begin
			if (info[i])
				zeros = 5'(i);  // Prefix length is the MSB position of codeNum+1
		end
	end

	assign code.len  = {zeros[3:0], 1'b1};
	assign code.bits = `ENC_CODE_W'(info);

	assign code_strobe = !pack_hold &&
		((state == enc_pkg::CS_LUMA && luma_level_valid) || state == enc_pkg::CS_CHROMA);
	assign flush       = !pack_hold && (state == enc_pkg::CS_FLUSH);
	assign take        = flush;  // Frees both quantisers once the last code is out

	always_ff @(posedge clk2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= enc_pkg::CS_IDLE;
			step  <= '0;
		end
		else
		begin
			case (state)
				enc_pkg::CS_IDLE:
				begin
					if (luma_ready && chroma_ready)
					begin
						state <= enc_pkg::CS_LUMA;
						step  <= '0;
					end
				end
				enc_pkg::CS_LUMA:
				begin
					if (code_strobe)
					begin
						if (step == 4'(`ENC_LUMA_COUNT - 1))
						begin
							state <= enc_pkg::CS_CHROMA;
							step  <= '0;
						end
						else
							step <= step + 4'd1;
					end
				end
				enc_pkg::CS_CHROMA:
				begin
					if (code_strobe)
					begin
						if (step == 4'(`ENC_CHROMA_COUNT - 1))
							state <= enc_pkg::CS_FLUSH;
						else
							step <= step + 4'd1;
					end
				end
				default:
				begin
					if (flush)
						state <= enc_pkg::CS_IDLE;
				end
			endcase
		end
	end

endmodule

//--- logic/chroma_dc_quant.sv
`timescale 1ns/100ps

module chroma_dc_quant
(
	input  logic                clk2,
	input  logic                arst_n,
	input  logic                mb_start,
	input  logic [5:0]          qp,
	input  logic                chroma_strobe,
	input  enc_pkg::chroma_dc_t chroma_dc,
	input  logic                take,
	input  logic [1:0]          level_idx,
	output logic                chroma_ready,
	output enc_pkg::level_t     chroma_level
);

	enc_pkg::level_t had    [0:3];
	enc_pkg::level_t levels [0:3];
	logic            had_valid;
	logic [3:0]      qdiv;
	logic [2:0]      qmod;

	function automatic logic [13:0] mf_dc(input logic [2:0] qm);
		case (qm)
			3'd0:    mf_dc = 14'd13107;
			3'd1:    mf_dc = 14'd11916;
			3'd2:    mf_dc = 14'd10082;
			3'd3:    mf_dc = 14'd9362;
			3'd4:    mf_dc = 14'd8192;
			default: mf_dc = 14'd7282;
		endcase
	endfunction

	function automatic enc_pkg::level_t quant_dc(input enc_pkg::level_t f, input logic [2:0] qm,
		input logic [3:0] qd);
		logic signed [31:0] fs;
		logic [31:0]        mag;
		logic [31:0]        prod;
		logic [4:0]         qbits;
		enc_pkg::level_t    lv;
		qbits    = 5'd15 + qd;
		fs       = f;
		mag      = (fs < 0) ? -fs : fs;
		prod     = mag * mf_dc(qm) + (((32'd1 << qbits) / 32'd3) << 1);  // Twice the luma offset
		lv       = enc_pkg::level_t'(prod >> (qbits + 5'd1));
		quant_dc = (fs < 0) ? -lv : lv;
	endfunction

	assign qdiv         = 4'(qp / 6'd6);
	assign qmod         = 3'(qp % 6'd6);
	assign chroma_level = levels[level_idx];

	always_ff @(posedge clk2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			had_valid    <= 1'b0;
			chroma_ready <= 1'b0;
		end
		else
		begin
			had_valid <= chroma_strobe;
			if (mb_start || take)
				chroma_ready <= 1'b0;
			else if (had_valid)
				chroma_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk2)
	begin
		if (chroma_strobe)
		begin
			had[0] <= chroma_dc.d0 + chroma_dc.d1 + chroma_dc.d2 + chroma_dc.d3;
			had[1] <= chroma_dc.d0 - chroma_dc.d1 + chroma_dc.d2 - chroma_dc.d3;
			had[2] <= chroma_dc.d0 + chroma_dc.d1 - chroma_dc.d2 - chroma_dc.d3;
			had[3] <= chroma_dc.d0 - chroma_dc.d1 - chroma_dc.d2 + chroma_dc.d3;
		end
		if (had_valid)
		begin
			for (int k = 0; k < 4; k++)
				levels[k] <= quant_dc(had[k], qmod, qdiv);
		end
	end

endmodule

//--- logic/luma_core_quant.sv
`timescale 1ns/100ps

module luma_core_quant
(
	input  logic                   clk2,
	input  logic                   arst_n,
	input  logic                   mb_start,
	input  logic [5:0]             qp,
	input  logic                   luma_strobe,
	input  enc_pkg::residual_row_t luma_row,
	input  logic                   take,
	input  logic [3:0]             level_idx,
	output logic                   luma_ready,
	output enc_pkg::level_t        luma_level,
	output logic                   luma_level_valid
);

	enc_pkg::level_t hrow   [0:3][0:3];  // Row pass results, [row][column]
	enc_pkg::level_t levels [0:15];      // Raster order
	logic [1:0]      row_cnt;
	logic [1:0]      step;
	logic            busy;
	logic [3:0]      qdiv;
	logic [2:0]      qmod;

	// One output of the 1,2,1,1 forward butterfly
	function automatic enc_pkg::level_t fwd(input logic [1:0] k, input enc_pkg::level_t a0,
		input enc_pkg::level_t a1, input enc_pkg::level_t a2, input enc_pkg::level_t a3);
		case (k)
			2'd0:    fwd = a0 + a1 + a2 + a3;
			2'd1:    fwd = (a0 <<< 1) + a1 - a2 - (a3 <<< 1);
			2'd2:    fwd = a0 - a1 - a2 + a3;
			default: fwd = a0 - (a1 <<< 1) + (a2 <<< 1) - a3;
		endcase
	endfunction

	function automatic enc_pkg::pos_class_t pos_class(input logic [1:0] u, input logic [1:0] v);
		if (!u[0] && !v[0])
			pos_class = enc_pkg::PC_A;
		else if (u[0] && v[0])
			pos_class = enc_pkg::PC_B;
		else
			pos_class = enc_pkg::PC_C;
	endfunction

	function automatic logic [13:0] mf(input logic [2:0] qm, input enc_pkg::pos_class_t pc);
		case (qm)
			3'd0:    mf = (pc == enc_pkg::PC_A) ? 14'd13107 : (pc == enc_pkg::PC_B) ? 14'd5243 : 14'd8066;
			3'd1:    mf = (pc == enc_pkg::PC_A) ? 14'd11916 : (pc == enc_pkg::PC_B) ? 14'd4660 : 14'd7490;
			3'd2:    mf = (pc == enc_pkg::PC_A) ? 14'd10082 : (pc == enc_pkg::PC_B) ? 14'd4194 : 14'd6554;
			3'd3:    mf = (pc == enc_pkg::PC_A) ? 14'd9362 : (pc == enc_pkg::PC_B) ? 14'd3647 : 14'd5825;
			3'd4:    mf = (pc == enc_pkg::PC_A) ? 14'd8192 : (pc == enc_pkg::PC_B) ? 14'd3355 : 14'd5243;
			default: mf = (pc == enc_pkg::PC_A) ? 14'd7282 : (pc == enc_pkg::PC_B) ? 14'd2893 : 14'd4559;
		endcase
	endfunction

	function automatic enc_pkg::level_t quant(input enc_pkg::level_t w, input enc_pkg::pos_class_t pc,
		input logic [2:0] qm, input logic [3:0] qd);
		logic signed [31:0] ws;
		logic [31:0]        mag;
		logic [31:0]        prod;
		logic [4:0]         qbits;
		enc_pkg::level_t    lv;
		qbits = 5'd15 + qd;
		ws    = w;
		mag   = (ws < 0) ? -ws : ws;
		prod  = mag * mf(qm, pc) + ((32'd1 << qbits) / 32'd3);
		lv    = enc_pkg::level_t'(prod >> qbits);
		quant = (ws < 0) ? -lv : lv;  // Sign follows the coefficient
	endfunction

	assign qdiv       = 4'(qp / 6'd6);
	assign qmod       = 3'(qp % 6'd6);
	assign luma_level = levels[level_idx];

	always_ff @(posedge clk2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			row_cnt          <= '0;
			step             <= '0;
			busy             <= 1'b0;
			luma_ready       <= 1'b0;
			luma_level_valid <= 1'b0;
		end
		else if (mb_start)
		begin
			row_cnt          <= '0;
			busy             <= 1'b0;
			luma_ready       <= 1'b0;
			luma_level_valid <= 1'b0;
		end
		else
		begin
			if (luma_strobe)
			begin
				row_cnt <= row_cnt + 2'd1;
				if (row_cnt == 2'd3)
				begin
					busy <= 1'b1;  // Row pass complete
					step <= '0;
				end
			end
			if (busy)
			begin
				step <= step + 2'd1;
				if (step == 2'd3)
				begin
					busy             <= 1'b0;
					luma_ready       <= 1'b1;
					luma_level_valid <= 1'b1;
				end
			end
			if (take)
				luma_ready <= 1'b0;
		end
	end

	always_ff @(posedge clk2)
	begin
		if (luma_strobe)
		begin
			for (int k = 0; k < 4; k++)
				hrow[row_cnt][k] <= fwd(2'(k), luma_row.s0, luma_row.s1, luma_row.s2, luma_row.s3);
		end
		if (busy)
		begin
			// Vertical pass yields output row step, quantised straight away
			for (int v = 0; v < 4; v++)
				levels[{step, 2'(v)}] <= quant(fwd(step, hrow[0][v], hrow[1][v], hrow[2][v], hrow[3][v]),
					pos_class(step, 2'(v)), qmod, qdiv);
		end
	end

endmodule

//--- logic/enc_pkg.sv
`include "enc_cfg.svh"

package enc_pkg;

	typedef struct packed {
		logic signed [`ENC_SAMPLE_W-1:0] s0;
		logic signed [`ENC_SAMPLE_W-1:0] s1;
		logic signed [`ENC_SAMPLE_W-1:0] s2;
		logic signed [`ENC_SAMPLE_W-1:0] s3;
	} residual_row_t;

	typedef struct packed {
		logic signed [`ENC_DC_IN_W-1:0] d0;  // Top left
		logic signed [`ENC_DC_IN_W-1:0] d1;
		logic signed [`ENC_DC_IN_W-1:0] d2;
		logic signed [`ENC_DC_IN_W-1:0] d3;
	} chroma_dc_t;

	typedef logic signed [`ENC_COEF_W-1:0] level_t;

	typedef struct packed {
		logic [`ENC_CODE_LEN_W-1:0] len;
		logic [`ENC_CODE_W-1:0]     bits;  // Right aligned, zero above len
	} vlc_code_t;

	typedef enum logic [1:0] {
		PC_A,
		PC_B,
		PC_C
	} pos_class_t;

	typedef enum logic [1:0] {
		CS_IDLE,
		CS_LUMA,
		CS_CHROMA,
		CS_FLUSH
	} coder_state_t;

endpackage

//--- include/enc_cfg.svh
`ifndef ENC_CFG_SVH
`define ENC_CFG_SVH

`define ENC_SAMPLE_W     9   // Signed luma residual sample
`define ENC_DC_IN_W      13  // Signed chroma DC input
`define ENC_COEF_W       16  // Transformed coefficient and quantised level

`define ENC_CODE_W       27  // Widest se(v) code in bits
`define ENC_CODE_LEN_W   5

`define ENC_LUMA_COUNT   16  // Levels per 4x4 luma block
`define ENC_CHROMA_COUNT 4   // Chroma DC levels per macroblock

`endif
